// ==== hw/ddr_test_pkg.sv ====
//**************************************
// DDR self-test shared definitions
// Widths, operation codes and the pattern rule
//**************************************
`default_nettype none

package ddr_test_pkg;

  // One memory word and the command fields
  typedef logic [63:0] data_t;
  typedef logic [31:0] seed_t;
  typedef logic [15:0] count_t;
  typedef logic [1:0]  resp_t;

  // AXI response code of a good transfer, anything else is an error
  localparam resp_t RESP_OKAY = 2'b00;

  // Address step between two test words
  localparam int WORD_BYTES = 8;

  // Test operation, code 3 is illegal
  typedef enum logic [1:0] {
    OP_WRITE       = 2'd0,
    OP_CHECK       = 2'd1,
    OP_WRITE_CHECK = 2'd2
  } test_op_e;

  // Bus sequencer states
  typedef enum logic [2:0] {
    IDLE,
    WR_REQ,
    WR_RESP,
    RD_REQ,
    RD_DATA,
    FINISH
  } exec_state_e;

  //**************************************
  // Data pattern
  //**************************************
  // Seed copied into both halves, xor the zero-extended byte address
  function automatic data_t pattern(input data_t addr, input seed_t seed);
    return {seed, seed} ^ addr;
  endfunction

endpackage

`default_nettype wire

// ==== hw/ddr_test_if.sv ====
//**************************************
// DDR self-test internal interfaces
// Accepted command and completed bus events
//**************************************
`timescale 1ns/1ps
`default_nettype none

interface ddr_test_cmd_if #(
  parameter int ADDR_WIDTH = 29
);
  logic                   cmd_valid;
  ddr_test_pkg::test_op_e op;
  logic [ADDR_WIDTH-1:0]  base_addr;
  ddr_test_pkg::count_t   word_count;
  ddr_test_pkg::seed_t    seed;
  // Engine running, driven by the sequencer
  logic                   busy;

  modport decode_mp (output cmd_valid, op, base_addr, word_count, seed, input busy);
  modport exec_mp (input cmd_valid, op, base_addr, word_count, seed, output busy);
  modport result_mp (input cmd_valid);
endinterface

interface ddr_test_rd_if #(
  parameter int ADDR_WIDTH = 29
);
  // Strobes are single cycle
  logic                  rd_valid;
  ddr_test_pkg::data_t   rd_data;
  ddr_test_pkg::data_t   exp_data;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  wr_err;
  logic                  rd_err;
  logic                  test_end;

  modport exec_mp (output rd_valid, rd_data, exp_data, rd_addr, wr_err, rd_err, test_end);
  modport result_mp (input rd_valid, rd_data, exp_data, rd_addr, wr_err, rd_err, test_end);
endinterface

`default_nettype wire

// ==== hw/ddr_test_decode.sv ====
//**************************************
// DDR self-test command decode
// Checks a start request and registers the command
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_decode #(
  parameter int ADDR_WIDTH = 29
) (
  input  wire                         c0_ddr4_clk,
  input  wire                         rst_i,
  input  wire                         start_i,
  input  wire ddr_test_pkg::test_op_e op_i,
  input  wire [ADDR_WIDTH-1:0]        base_addr_i,
  input  wire ddr_test_pkg::count_t   word_count_i,
  input  wire ddr_test_pkg::seed_t    seed_i,
  input  wire                         calib_complete_i,
  output logic                        reject_o,
  ddr_test_cmd_if.decode_mp           cmd
);

  logic                   accept;
  logic                   cmd_valid_q;
  logic                   reject_q;
  ddr_test_pkg::test_op_e op_q;
  logic [ADDR_WIDTH-1:0]  base_q;
  ddr_test_pkg::count_t   count_q;
  ddr_test_pkg::seed_t    seed_q;

  // A command still in the strobe cycle counts as busy too
  assign accept = start_i && calib_complete_i && !cmd.busy && !cmd_valid_q &&
                  (op_i inside {ddr_test_pkg::OP_WRITE, ddr_test_pkg::OP_CHECK,
                                ddr_test_pkg::OP_WRITE_CHECK}) &&
                  (word_count_i != '0);

  // Strobes
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      cmd_valid_q <= 1'b0;
      reject_q    <= 1'b0;
    end else begin
      cmd_valid_q <= accept;
      reject_q    <= start_i && !accept;
    end
  end

  // Command fields held until the next accepted start
  always_ff @(posedge c0_ddr4_clk) begin
    if (accept) begin
      op_q    <= op_i;
      base_q  <= base_addr_i;
      count_q <= word_count_i;
      seed_q  <= seed_i;
    end
  end

  assign cmd.cmd_valid  = cmd_valid_q;
  assign cmd.op         = op_q;
  assign cmd.base_addr  = base_q;
  assign cmd.word_count = count_q;
  assign cmd.seed       = seed_q;
  assign reject_o       = reject_q;

endmodule

`default_nettype wire

// ==== hw/ddr_test_execute.sv ====
//**************************************
// DDR self-test bus sequencer
// Single-beat AXI writes and reads, one word at a time
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_execute #(
  parameter int ADDR_WIDTH = 29
) (
  input  wire                        c0_ddr4_clk,
  input  wire                        rst_i,
  // Write address
  output logic                       aw_valid_o,
  input  wire                        aw_ready_i,
  output logic [ADDR_WIDTH-1:0]      aw_addr_o,
  // Write data
  output logic                       w_valid_o,
  input  wire                        w_ready_i,
  output ddr_test_pkg::data_t        w_data_o,
  // Write response
  input  wire                        b_valid_i,
  output logic                       b_ready_o,
  input  wire ddr_test_pkg::resp_t   b_resp_i,
  // Read address
  output logic                       ar_valid_o,
  input  wire                        ar_ready_i,
  output logic [ADDR_WIDTH-1:0]      ar_addr_o,
  // Read data
  input  wire                        r_valid_i,
  output logic                       r_ready_o,
  input  wire ddr_test_pkg::data_t   r_data_i,
  input  wire ddr_test_pkg::resp_t   r_resp_i,
  ddr_test_cmd_if.exec_mp            cmd,
  ddr_test_rd_if.exec_mp             rd
);

  ddr_test_pkg::exec_state_e state_q;
  logic [ADDR_WIDTH-1:0]     addr_q;
  logic [ADDR_WIDTH-1:0]     next_addr;
  ddr_test_pkg::count_t      idx_q;
  logic                      aw_done_q;
  logic                      w_done_q;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      last_word;
  ddr_test_pkg::data_t       exp_data;

  assign next_addr = addr_q + ADDR_WIDTH'(ddr_test_pkg::WORD_BYTES);
  assign last_word = (idx_q == cmd.word_count - ddr_test_pkg::count_t'(1));
  assign exp_data  = ddr_test_pkg::pattern(ddr_test_pkg::data_t'(addr_q), cmd.seed);

  //**************************************
  // AXI channel outputs
  //**************************************
  // AW and W rise together and drop on their own handshake
  assign aw_valid_o = (state_q == ddr_test_pkg::WR_REQ) && !aw_done_q;
  assign w_valid_o  = (state_q == ddr_test_pkg::WR_REQ) && !w_done_q;
  assign aw_addr_o  = addr_q;
  assign w_data_o   = exp_data;
  assign b_ready_o  = (state_q == ddr_test_pkg::WR_RESP);
  assign ar_valid_o = (state_q == ddr_test_pkg::RD_REQ);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == ddr_test_pkg::RD_DATA);

  assign aw_hs = aw_valid_o && aw_ready_i;
  assign w_hs  = w_valid_o && w_ready_i;

  //**************************************
  // Sequencer
  //**************************************
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      state_q   <= ddr_test_pkg::IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        ddr_test_pkg::IDLE: begin
          if (cmd.cmd_valid) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            if (cmd.op == ddr_test_pkg::OP_CHECK) begin
              state_q <= ddr_test_pkg::RD_REQ;
            end else begin
              state_q <= ddr_test_pkg::WR_REQ;
            end
          end
        end
        ddr_test_pkg::WR_REQ: begin
          if (aw_hs) begin
            aw_done_q <= 1'b1;
          end
          if (w_hs) begin
            w_done_q <= 1'b1;
          end
          // Both halves of the write accepted
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            state_q   <= ddr_test_pkg::WR_RESP;
          end
        end
        ddr_test_pkg::WR_RESP: begin
          if (b_valid_i) begin
            if (!last_word) begin
              state_q <= ddr_test_pkg::WR_REQ;
            end else if (cmd.op == ddr_test_pkg::OP_WRITE_CHECK) begin
              state_q <= ddr_test_pkg::RD_REQ;
            end else begin
              state_q <= ddr_test_pkg::FINISH;
            end
          end
        end
        ddr_test_pkg::RD_REQ: begin
          if (ar_ready_i) begin
            state_q <= ddr_test_pkg::RD_DATA;
          end
        end
        ddr_test_pkg::RD_DATA: begin
          if (r_valid_i) begin
            state_q <= last_word ? ddr_test_pkg::FINISH : ddr_test_pkg::RD_REQ;
          end
        end
        default: begin
          state_q <= ddr_test_pkg::IDLE;
        end
      endcase
    end
  end

  // Word address and index, rewound to the base for the read pass
  always_ff @(posedge c0_ddr4_clk) begin
    if ((state_q == ddr_test_pkg::IDLE && cmd.cmd_valid) ||
        (state_q == ddr_test_pkg::WR_RESP && b_valid_i && last_word)) begin
      addr_q <= cmd.base_addr;
      idx_q  <= '0;
    end else if ((state_q == ddr_test_pkg::WR_RESP && b_valid_i) ||
                 (state_q == ddr_test_pkg::RD_DATA && r_valid_i)) begin
      addr_q <= next_addr;
      idx_q  <= idx_q + ddr_test_pkg::count_t'(1);
    end
  end

  //**************************************
  // Events to the result block
  //**************************************
  assign rd.rd_valid = (state_q == ddr_test_pkg::RD_DATA) && r_valid_i;
  assign rd.rd_data  = r_data_i;
  assign rd.exp_data = exp_data;
  assign rd.rd_addr  = addr_q;
  assign rd.wr_err   = b_ready_o && b_valid_i && (b_resp_i != ddr_test_pkg::RESP_OKAY);
  assign rd.rd_err   = r_ready_o && r_valid_i && (r_resp_i != ddr_test_pkg::RESP_OKAY);
  assign rd.test_end = (state_q == ddr_test_pkg::FINISH);
  assign cmd.busy    = (state_q != ddr_test_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hw/ddr_test_result.sv ====
//**************************************
// DDR self-test result
// Read data compare and sticky error status
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_result #(
  parameter int ADDR_WIDTH = 29
) (
  input  wire                   c0_ddr4_clk,
  input  wire                   rst_i,
  ddr_test_cmd_if.result_mp     cmd,
  ddr_test_rd_if.result_mp      rd,
  output logic                  done_o,
  output ddr_test_pkg::count_t  mismatch_count_o,
  output logic [ADDR_WIDTH-1:0] first_fail_addr_o,
  output logic                  write_err_o,
  output logic                  read_err_o,
  output logic                  compare_error_o
);

  ddr_test_pkg::count_t  mismatch_q;
  logic [ADDR_WIDTH-1:0] first_fail_q;
  logic                  fail_seen_q;
  logic                  wr_err_q;
  logic                  rd_err_q;
  logic                  done_q;
  logic                  mismatch;

  assign mismatch = rd.rd_valid && (rd.rd_data != rd.exp_data);

  // A new command clears the status of the previous test
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i || cmd.cmd_valid) begin
      mismatch_q   <= '0;
      first_fail_q <= '0;
      fail_seen_q  <= 1'b0;
      wr_err_q     <= 1'b0;
      rd_err_q     <= 1'b0;
    end else begin
      if (mismatch) begin
        // Count saturates at all ones
        if (mismatch_q != '1) begin
          mismatch_q <= mismatch_q + ddr_test_pkg::count_t'(1);
        end
        if (!fail_seen_q) begin
          first_fail_q <= rd.rd_addr;
          fail_seen_q  <= 1'b1;
        end
      end
      if (rd.wr_err) begin
        wr_err_q <= 1'b1;
      end
      if (rd.rd_err) begin
        rd_err_q <= 1'b1;
      end
    end
  end

  // Done follows the end strobe, so all counts are final by then
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= rd.test_end;
    end
  end

  assign done_o            = done_q;
  assign mismatch_count_o  = mismatch_q;
  assign first_fail_addr_o = first_fail_q;
  assign write_err_o       = wr_err_q;
  assign read_err_o        = rd_err_q;
  assign compare_error_o   = fail_seen_q | wr_err_q | rd_err_q;

endmodule

`default_nettype wire

// ==== hw/ddr_test_top.sv ====
//**************************************
// DDR self-test engine top level
// AXI master that writes, reads back and checks memory
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_top #(
  parameter int ADDR_WIDTH = 29
) (
  input  wire                         c0_ddr4_clk,
  input  wire                         rst_i,
  input  wire                         calib_complete_i,
  // Test command
  input  wire                         start_i,
  input  wire ddr_test_pkg::test_op_e op_i,
  input  wire [ADDR_WIDTH-1:0]        base_addr_i,
  input  wire ddr_test_pkg::count_t   word_count_i,
  input  wire ddr_test_pkg::seed_t    seed_i,
  // AXI master
  output logic                        aw_valid_o,
  input  wire                         aw_ready_i,
  output logic [ADDR_WIDTH-1:0]       aw_addr_o,
  output logic                        w_valid_o,
  input  wire                         w_ready_i,
  output ddr_test_pkg::data_t         w_data_o,
  input  wire                         b_valid_i,
  output logic                        b_ready_o,
  input  wire ddr_test_pkg::resp_t    b_resp_i,
  output logic                        ar_valid_o,
  input  wire                         ar_ready_i,
  output logic [ADDR_WIDTH-1:0]       ar_addr_o,
  input  wire                         r_valid_i,
  output logic                        r_ready_o,
  input  wire ddr_test_pkg::data_t    r_data_i,
  input  wire ddr_test_pkg::resp_t    r_resp_i,
  // Status
  output logic                        reject_o,
  output logic                        busy_o,
  output logic                        done_o,
  output ddr_test_pkg::count_t        mismatch_count_o,
  output logic [ADDR_WIDTH-1:0]       first_fail_addr_o,
  output logic                        write_err_o,
  output logic                        read_err_o,
  output logic                        compare_error_o
);

  ddr_test_cmd_if #(.ADDR_WIDTH(ADDR_WIDTH)) cmd_if ();
  ddr_test_rd_if  #(.ADDR_WIDTH(ADDR_WIDTH)) rd_if ();

  ddr_test_decode #(.ADDR_WIDTH(ADDR_WIDTH)) u_decode (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .rst_i            (rst_i),
    .start_i          (start_i),
    .op_i             (op_i),
    .base_addr_i      (base_addr_i),
    .word_count_i     (word_count_i),
    .seed_i           (seed_i),
    .calib_complete_i (calib_complete_i),
    .reject_o         (reject_o),
    .cmd              (cmd_if.decode_mp)
  );

  ddr_test_execute #(.ADDR_WIDTH(ADDR_WIDTH)) u_execute (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_i       (rst_i),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_addr_o   (aw_addr_o),
    .w_valid_o   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .w_data_o    (w_data_o),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .b_resp_i    (b_resp_i),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .r_valid_i   (r_valid_i),
    .r_ready_o   (r_ready_o),
    .r_data_i    (r_data_i),
    .r_resp_i    (r_resp_i),
    .cmd         (cmd_if.exec_mp),
    .rd          (rd_if.exec_mp)
  );

  ddr_test_result #(.ADDR_WIDTH(ADDR_WIDTH)) u_result (
    .c0_ddr4_clk       (c0_ddr4_clk),
    .rst_i             (rst_i),
    .cmd               (cmd_if.result_mp),
    .rd                (rd_if.result_mp),
    .done_o            (done_o),
    .mismatch_count_o  (mismatch_count_o),
    .first_fail_addr_o (first_fail_addr_o),
    .write_err_o       (write_err_o),
    .read_err_o        (read_err_o),
    .compare_error_o   (compare_error_o)
  );

  assign busy_o = cmd_if.busy;

endmodule

`default_nettype wire

// ==== test/ddr_test_assert.sv ====
//**************************************
// DDR self-test AXI and status checks
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_assert #(
  parameter int ADDR_WIDTH = 29
) (
  input wire                  c0_ddr4_clk,
  input wire                  rst_i,
  input wire                  aw_valid_o,
  input wire                  aw_ready_i,
  input wire [ADDR_WIDTH-1:0] aw_addr_o,
  input wire                  w_valid_o,
  input wire                  w_ready_i,
  input wire [63:0]           w_data_o,
  input wire                  b_valid_i,
  input wire                  b_ready_o,
  input wire                  ar_valid_o,
  input wire                  ar_ready_i,
  input wire [ADDR_WIDTH-1:0] ar_addr_o,
  input wire                  done_o
);

  // Write open from address acceptance to its response
  logic wr_open_q;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst_i || (b_valid_i && b_ready_o)) begin
      wr_open_q <= 1'b0;
    end else if (aw_valid_o && aw_ready_i) begin
      wr_open_q <= 1'b1;
    end
  end

  aw_stable: assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
    else $error("AW changed before ready");
  w_stable: assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else $error("W changed before ready");
  ar_stable: assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("AR changed before ready");
  ar_after_write: assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    ar_valid_o |-> !wr_open_q)
    else $error("AR raised with a write outstanding");
  done_pulse: assert property (@(posedge c0_ddr4_clk) disable iff (rst_i)
    done_o |=> !done_o)
    else $error("done held for more than one cycle");
  quiet_after_reset: assert property (@(posedge c0_ddr4_clk)
    $fell(rst_i) |-> !aw_valid_o && !w_valid_o && !ar_valid_o)
    else $error("valid high right after reset");

endmodule

bind ddr_test_top ddr_test_assert #(.ADDR_WIDTH(ADDR_WIDTH)) u_assert (
  .c0_ddr4_clk (c0_ddr4_clk),
  .rst_i       (rst_i),
  .aw_valid_o  (aw_valid_o),
  .aw_ready_i  (aw_ready_i),
  .aw_addr_o   (aw_addr_o),
  .w_valid_o   (w_valid_o),
  .w_ready_i   (w_ready_i),
  .w_data_o    (w_data_o),
  .b_valid_i   (b_valid_i),
  .b_ready_o   (b_ready_o),
  .ar_valid_o  (ar_valid_o),
  .ar_ready_i  (ar_ready_i),
  .ar_addr_o   (ar_addr_o),
  .done_o      (done_o)
);

`default_nettype wire

// ==== test/ddr_test_tb.sv ====
//**************************************
// DDR self-test engine testbench
// AXI memory model, directed tests and summary
//**************************************
`timescale 1ns/1ps
`default_nettype none

module ddr_test_tb;

  localparam int AW = 29;
  // Bus transfers of the directed tests and of four random 64-word runs
  localparam int TOTAL_WORDS = 64 + 32 + 16 + 16 + 512;

  logic                   c0_ddr4_clk;
  logic                   rst_i;
  logic                   calib_complete_i;
  logic                   start_i;
  ddr_test_pkg::test_op_e op_i;
  logic [AW-1:0]          base_addr_i;
  ddr_test_pkg::count_t   word_count_i;
  ddr_test_pkg::seed_t    seed_i;
  logic                   aw_valid_o, aw_ready_i;
  logic [AW-1:0]          aw_addr_o;
  logic                   w_valid_o, w_ready_i;
  ddr_test_pkg::data_t    w_data_o;
  logic                   b_valid_i, b_ready_o;
  ddr_test_pkg::resp_t    b_resp_i;
  logic                   ar_valid_o, ar_ready_i;
  logic [AW-1:0]          ar_addr_o;
  logic                   r_valid_i, r_ready_o;
  ddr_test_pkg::data_t    r_data_i;
  ddr_test_pkg::resp_t    r_resp_i;
  logic                   reject_o, busy_o, done_o;
  ddr_test_pkg::count_t   mismatch_count_o;
  logic [AW-1:0]          first_fail_addr_o;
  logic                   write_err_o, read_err_o, compare_error_o;

  int unsigned errors;
  int unsigned checks;
  int unsigned valid_cycles;

  ddr_test_top #(.ADDR_WIDTH(AW)) dut (.*);

  initial begin
    c0_ddr4_clk = 1'b0;
  end

  always #50 c0_ddr4_clk = ~c0_ddr4_clk;

  //**************************************
  // AXI memory model
  //**************************************
  ddr_test_pkg::data_t mem [logic [63:0]];
  logic                aw_got, w_got, ar_got;
  logic [63:0]         wr_addr, rd_addr;
  ddr_test_pkg::data_t wr_data;
  int                  aw_wait, w_wait, b_wait, ar_wait, r_wait;
  // Fault injection
  logic                wr_fault_en, rd_fault_en;
  logic [63:0]         wr_fault_addr, rd_fault_addr;

  // Ready set here completes on the following rising edge
  always @(negedge c0_ddr4_clk) begin
    if (rst_i) begin
      aw_ready_i = 1'b0;
      w_ready_i  = 1'b0;
      ar_ready_i = 1'b0;
      b_valid_i  = 1'b0;
      r_valid_i  = 1'b0;
      aw_got     = 1'b0;
      w_got      = 1'b0;
      ar_got     = 1'b0;
    end else begin
      aw_ready_i = 1'b0;
      if (aw_valid_o && !aw_got) begin
        if (aw_wait == 0) begin
          aw_ready_i = 1'b1;
          aw_got     = 1'b1;
          wr_addr    = 64'(aw_addr_o);
          aw_wait    = int'($urandom_range(3, 0));
        end else begin
          aw_wait--;
        end
      end
      w_ready_i = 1'b0;
      if (w_valid_o && !w_got) begin
        if (w_wait == 0) begin
          w_ready_i = 1'b1;
          w_got     = 1'b1;
          wr_data   = w_data_o;
          w_wait    = int'($urandom_range(3, 0));
        end else begin
          w_wait--;
        end
      end
      // A raised response is taken on the next edge since b_ready stays high in WR_RESP
      if (b_valid_i) begin
        b_valid_i = 1'b0;
      end else if (aw_got && w_got && b_ready_o) begin
        if (b_wait == 0) begin
          mem[wr_addr] = wr_data;
          b_valid_i    = 1'b1;
          b_resp_i     = (wr_fault_en && wr_addr == wr_fault_addr) ? 2'b10 : 2'b00;
          aw_got       = 1'b0;
          w_got        = 1'b0;
          b_wait       = int'($urandom_range(3, 0));
        end else begin
          b_wait--;
        end
      end
      ar_ready_i = 1'b0;
      if (ar_valid_o && !ar_got) begin
        if (ar_wait == 0) begin
          ar_ready_i = 1'b1;
          ar_got     = 1'b1;
          rd_addr    = 64'(ar_addr_o);
          ar_wait    = int'($urandom_range(3, 0));
        end else begin
          ar_wait--;
        end
      end
      if (r_valid_i) begin
        r_valid_i = 1'b0;
      end else if (ar_got && r_ready_o) begin
        if (r_wait == 0) begin
          r_valid_i = 1'b1;
          r_data_i  = mem.exists(rd_addr) ? mem[rd_addr] : '0;
          r_resp_i  = (rd_fault_en && rd_addr == rd_fault_addr) ? 2'b10 : 2'b00;
          ar_got    = 1'b0;
          r_wait    = int'($urandom_range(3, 0));
        end else begin
          r_wait--;
        end
      end
    end
  end

  // Bus activity seen by the reject tests
  always @(posedge c0_ddr4_clk) begin
    if (aw_valid_o || w_valid_o || ar_valid_o) begin
      valid_cycles++;
    end
  end

  //**************************************
  // Helpers
  //**************************************
  function automatic ddr_test_pkg::data_t expected_word(input logic [63:0] addr,
                                                        input ddr_test_pkg::seed_t seed);
    return {seed, seed} ^ addr;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic issue_start(input logic [1:0] op, input logic [AW-1:0] base,
                             input ddr_test_pkg::count_t count,
                             input ddr_test_pkg::seed_t seed);
    @(negedge c0_ddr4_clk);
    start_i      = 1'b1;
    op_i         = ddr_test_pkg::test_op_e'(op);
    base_addr_i  = base;
    word_count_i = count;
    seed_i       = seed;
    @(negedge c0_ddr4_clk);
    start_i = 1'b0;
  endtask

  // Returns on the done or reject pulse
  task automatic wait_end(output logic got_done, output logic got_reject);
    while (!done_o && !reject_o) begin
      @(negedge c0_ddr4_clk);
    end
    got_done   = done_o;
    got_reject = reject_o;
  endtask

  task automatic run_test(input logic [1:0] op, input logic [AW-1:0] base,
                          input ddr_test_pkg::count_t count, input ddr_test_pkg::seed_t seed);
    logic got_done;
    logic got_reject;
    issue_start(op, base, count, seed);
    wait_end(got_done, got_reject);
    checks++;
    assert (got_done && !got_reject) else begin
      errors++;
      $display("command at base %h was rejected instead of finishing", base);
    end
    // The engine is idle again once done pulses
    compare_value("busy_o", 64'(busy_o), 64'd0);
  endtask

  task automatic check_memory(input logic [AW-1:0] base, input int count,
                              input ddr_test_pkg::seed_t seed);
    logic [63:0] a;
    for (int i = 0; i < count; i++) begin
      a = 64'(base) + 64'(i * ddr_test_pkg::WORD_BYTES);
      checks++;
      assert (mem.exists(a)) else begin
        errors++;
        $display("memory word at %h was never written", a);
      end
      if (mem.exists(a)) begin
        compare_value("mem", mem[a], expected_word(a, seed));
      end
    end
  endtask

  task automatic check_status(input logic [15:0] mism, input logic [AW-1:0] first,
                              input logic wr_e, input logic rd_e, input logic cmp_e);
    compare_value("mismatch_count_o", 64'(mismatch_count_o), 64'(mism));
    compare_value("first_fail_addr_o", 64'(first_fail_addr_o), 64'(first));
    compare_value("write_err_o", 64'(write_err_o), 64'(wr_e));
    compare_value("read_err_o", 64'(read_err_o), 64'(rd_e));
    compare_value("compare_error_o", 64'(compare_error_o), 64'(cmp_e));
  endtask

  // Expects a reject pulse, no bus traffic and the status left as it was
  task automatic expect_reject(input logic [1:0] op, input ddr_test_pkg::count_t count);
    logic got_done;
    logic got_reject;
    logic [15:0] mism;
    logic [AW-1:0] first;
    logic wr_e, rd_e, cmp_e;
    mism  = mismatch_count_o;
    first = first_fail_addr_o;
    wr_e  = write_err_o;
    rd_e  = read_err_o;
    cmp_e = compare_error_o;
    valid_cycles = 0;
    issue_start(op, AW'(32'h0000_2000), count, 32'h1234_5678);
    wait_end(got_done, got_reject);
    repeat (8) @(negedge c0_ddr4_clk);
    compare_value("reject_o", 64'(got_reject), 64'd1);
    compare_value("done_o", 64'(got_done), 64'd0);
    compare_value("valid_cycles", 64'(valid_cycles), 64'd0);
    check_status(mism, first, wr_e, rd_e, cmp_e);
  endtask

  //**************************************
  // Directed tests
  //**************************************
  task automatic test_write_check_clean();
    run_test(2'd2, AW'(32'h0000_1000), 16'd32, 32'hA5A5_0F0F);
    check_status(16'd0, '0, 1'b0, 1'b0, 1'b0);
    check_memory(AW'(32'h0000_1000), 32, 32'hA5A5_0F0F);
  endtask

  task automatic test_corrupted_words();
    logic [63:0] base;
    base = 64'h0010_0000;
    run_test(2'd0, AW'(base), 16'd16, 32'h5A5A_C3C3);
    mem[base + 64'd96] ^= 64'h0000_0100_0000_0000;
    mem[base + 64'd24] ^= 64'h1;
    mem[base + 64'd56] ^= 64'h8000_0000_0000_0000;
    run_test(2'd1, AW'(base), 16'd16, 32'h5A5A_C3C3);
    check_status(16'd3, AW'(base + 64'd24), 1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_response_errors();
    logic [63:0] base;
    base = 64'h0020_0000;
    wr_fault_en   = 1'b1;
    wr_fault_addr = base + 64'd8;
    run_test(2'd2, AW'(base), 16'd4, 32'h0BAD_F00D);
    wr_fault_en = 1'b0;
    check_status(16'd0, '0, 1'b1, 1'b0, 1'b1);
    rd_fault_en   = 1'b1;
    rd_fault_addr = base + 64'd16;
    run_test(2'd1, AW'(base), 16'd4, 32'h0BAD_F00D);
    rd_fault_en = 1'b0;
    check_status(16'd0, '0, 1'b0, 1'b1, 1'b1);
    run_test(2'd1, AW'(base), 16'd4, 32'h0BAD_F00D);
    check_status(16'd0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_start_while_busy();
    logic got_done;
    logic got_reject;
    issue_start(2'd2, AW'(32'h0030_0000), 16'd8, 32'h7777_1111);
    while (!busy_o) begin
      @(negedge c0_ddr4_clk);
    end
    issue_start(2'd1, AW'(32'h0040_0000), 16'd4, 32'h0);
    wait_end(got_done, got_reject);
    compare_value("reject_o", 64'(got_reject), 64'd1);
    @(negedge c0_ddr4_clk);
    wait_end(got_done, got_reject);
    compare_value("done_o", 64'(got_done), 64'd1);
    check_status(16'd0, '0, 1'b0, 1'b0, 1'b0);
    check_memory(AW'(32'h0030_0000), 8, 32'h7777_1111);
  endtask

  task automatic test_random_runs();
    logic [AW-1:0]       base;
    ddr_test_pkg::seed_t seed;
    for (int n = 0; n < 4; n++) begin
      base = AW'($urandom & 32'h1FFF_F000);
      seed = $urandom;
      run_test(2'd2, base, 16'd64, seed);
      check_status(16'd0, '0, 1'b0, 1'b0, 1'b0);
      check_memory(base, 64, seed);
    end
  endtask

  //**************************************
  // Main sequence and watchdog
  //**************************************
  initial begin
    int unsigned first_rnd;
    first_rnd        = $urandom(32'h96d84f44);
    errors           = 0;
    checks           = 0;
    valid_cycles     = 0;
    rst_i            = 1'b1;
    calib_complete_i = 1'b0;
    start_i          = 1'b0;
    op_i             = ddr_test_pkg::OP_WRITE;
    base_addr_i      = '0;
    word_count_i     = '0;
    seed_i           = '0;
    aw_ready_i       = 1'b0;
    w_ready_i        = 1'b0;
    b_valid_i        = 1'b0;
    b_resp_i         = 2'b00;
    ar_ready_i       = 1'b0;
    r_valid_i        = 1'b0;
    r_data_i         = '0;
    r_resp_i         = 2'b00;
    wr_fault_en      = 1'b0;
    rd_fault_en      = 1'b0;
    wr_fault_addr    = '0;
    rd_fault_addr    = '0;
    aw_wait          = int'(first_rnd % 4);
    w_wait           = 0;
    b_wait           = 0;
    ar_wait          = 0;
    r_wait           = 0;
    repeat (10) @(negedge c0_ddr4_clk);
    rst_i = 1'b0;
    repeat (2) @(negedge c0_ddr4_clk);
    // Calibration still pending
    expect_reject(2'd2, 16'd4);
    calib_complete_i = 1'b1;
    test_write_check_clean();
    test_corrupted_words();
    expect_reject(2'd3, 16'd4);
    expect_reject(2'd2, 16'd0);
    test_response_errors();
    test_start_while_busy();
    test_random_runs();
    repeat (4) @(negedge c0_ddr4_clk);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (TOTAL_WORDS * 20 + 1000) @(posedge c0_ddr4_clk);
    $display("watchdog expired before all tests finished, errors so far: %0d", errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/ddr_test_pkg.sv
hw/ddr_test_if.sv
hw/ddr_test_decode.sv
hw/ddr_test_execute.sv
hw/ddr_test_result.sv
hw/ddr_test_top.sv
test/ddr_test_assert.sv
test/ddr_test_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the DDR self-test simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  -f sources.f \
  --top-module ddr_test_tb \
  -o ddr_test_sim

./obj_dir/ddr_test_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
